// File: hw/fifo_pkg.sv
// FIFO geometry package
// Default storage shape of the credit FIFO subsystem: number of entries,
// entry width and whether an empty FIFO forwards a push straight to pop

package fifo_pkg;

  // ------------------------------
  // Storage geometry
  // ------------------------------

  // Number of entries held in the RAM
  // The controller needs at least two to keep its pointers meaningful
  parameter int default_depth = 4;

  // Width of one entry in bits
  parameter int default_bit_width = 8;

  // ------------------------------
  // Empty-FIFO path
  // ------------------------------

  // With 1 a push into an empty FIFO reaches pop in the same cycle
  // With 0 every entry passes through the RAM first, one cycle later
  parameter bit default_enable_bypass = 1'b1;

endpackage : fifo_pkg

// File: hw/credit_pkg.sv
// Credit protocol package
// Default ceiling of the push credit counter and the rule that sizes
// every credit field from that ceiling

package credit_pkg;

  // ------------------------------
  // Credit counter
  // ------------------------------

  // Largest value the credit counter can hold
  // It must cover the FIFO depth, so the smallest legal choice is the depth
  parameter int default_max_credit = fifo_pkg::default_depth;

  // Width of a credit field that counts from zero up to max_credit
  function automatic int credit_width(int max_credit);
    return $clog2(max_credit + 1);
  endfunction

endpackage : credit_pkg

// File: hw/fifo_push_ctrl_credit.sv
// FIFO push controller, credit/valid variant
// Returns credits to the sender, accepts pushes, and steers each push
// either onto the bypass path or into the RAM at the write pointer.
// Keeps its own copy of the occupancy as free slots

`timescale 1ns/1ps

module fifo_push_ctrl_credit #(
  parameter int depth = 4,
  parameter int bit_width = 8,
  parameter bit enable_bypass = 1'b1,
  parameter int max_credit = depth,
  localparam int addr_width = $clog2(depth),
  localparam int count_width = $clog2(depth + 1),
  localparam int credit_width = credit_pkg::credit_width(max_credit)
) (
  input  logic                    clk,
  input  logic                    rst_n,
  // Push interface
  input  logic                    push_credit_stall,
  output logic                    push_credit,
  input  logic                    push_valid,
  input  logic [bit_width-1:0]    push_data,
  // Status
  output logic                    full,
  output logic                    full_next,
  output logic [count_width-1:0]  slots,
  output logic [count_width-1:0]  slots_next,
  // Credit configuration and state
  input  logic [credit_width-1:0] credit_initial_push,
  input  logic [credit_width-1:0] credit_withhold_push,
  output logic [credit_width-1:0] credit_count_push,
  // Bypass offer towards the pop controller
  input  logic                    bypass_ready,
  output logic                    bypass_valid_unstable,
  output logic [bit_width-1:0]    bypass_data_unstable,
  // RAM write port and occupancy strobes
  output logic                    ram_wr_valid,
  output logic [addr_width-1:0]   ram_wr_addr,
  output logic [bit_width-1:0]    ram_wr_data,
  output logic                    ram_push,
  input  logic                    ram_pop
);

  logic                    credit_loaded;
  logic                    empty_local;
  logic                    bypass_taken;
  logic                    credit_incr;
  logic [credit_width-1:0] credit_base;
  logic [credit_width-1:0] credit_count_next;
  logic [addr_width-1:0]   wr_addr;

  // ------------------------------
  // Bypass steering
  // ------------------------------

  // The FIFO is empty when every slot is free
  assign empty_local = (slots == count_width'(depth));

  // A push into an empty FIFO is offered to the pop side first
  // The offer is unstable since it can vanish when the push does
  assign bypass_valid_unstable = enable_bypass && push_valid && empty_local;
  assign bypass_data_unstable  = push_data;
  assign bypass_taken          = bypass_valid_unstable && bypass_ready;

  // Anything the pop side did not take goes into the RAM
  assign ram_push     = push_valid && !bypass_taken;
  assign ram_wr_valid = ram_push;
  assign ram_wr_addr  = wr_addr;
  assign ram_wr_data  = push_data;

  // Write pointer wraps at the last entry so depth need not be a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_addr <= '0;
    end else if (ram_push) begin
      if (wr_addr == addr_width'(depth - 1)) begin
        wr_addr <= '0;
      end else begin
        wr_addr <= wr_addr + 1'b1;
      end
    end
  end

  // ------------------------------
  // Slot count
  // ------------------------------

  assign slots_next = slots - count_width'(ram_push) + count_width'(ram_pop);
  assign full_next  = (slots_next == '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slots <= count_width'(depth);
      full  <= 1'b0;
    end else begin
      slots <= slots_next;
      full  <= full_next;
    end
  end

  // ------------------------------
  // Credit counter
  // ------------------------------

  // Every entry that leaves the FIFO, through the RAM or the bypass,
  // frees one credit for the sender
  assign credit_incr = ram_pop || bypass_taken;

  // Credits go back one per cycle, only from the registered count,
  // and credit_withhold_push of them stay behind
  assign push_credit = !push_credit_stall && (credit_count_push > credit_withhold_push);

  // The first cycle after reset replaces the zero count with the initial value
  assign credit_base = credit_loaded ? credit_count_push : credit_initial_push;
  assign credit_count_next = credit_base + credit_width'(credit_incr)
                           - credit_width'(push_credit);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit_loaded     <= 1'b0;
      credit_count_push <= '0;
    end else begin
      credit_loaded     <= 1'b1;
      credit_count_push <= credit_count_next;
    end
  end

endmodule : fifo_push_ctrl_credit

// File: hw/fifo_pop_ctrl.sv
// FIFO pop controller, ready/valid variant
// Presents the head entry on pop, taken from the bypass offer while the
// FIFO is empty and from the RAM read port otherwise. Keeps the read
// pointer and its own copy of the occupancy as an item count

`timescale 1ns/1ps

module fifo_pop_ctrl #(
  parameter int depth = 4,
  parameter int bit_width = 8,
  parameter bit enable_bypass = 1'b1,
  localparam int addr_width = $clog2(depth),
  localparam int count_width = $clog2(depth + 1)
) (
  input  logic                   clk,
  input  logic                   rst_n,
  // Pop interface
  input  logic                   pop_ready,
  output logic                   pop_valid,
  output logic [bit_width-1:0]   pop_data,
  // Status
  output logic                   empty,
  output logic                   empty_next,
  output logic [count_width-1:0] items,
  output logic [count_width-1:0] items_next,
  // Bypass offer from the push controller
  output logic                   bypass_ready,
  input  logic                   bypass_valid_unstable,
  input  logic [bit_width-1:0]   bypass_data_unstable,
  // RAM read port and occupancy strobes
  output logic                   ram_rd_addr_valid,
  output logic [addr_width-1:0]  ram_rd_addr,
  input  logic                   ram_rd_data_valid,
  input  logic [bit_width-1:0]   ram_rd_data,
  input  logic                   ram_push,
  output logic                   ram_pop
);

  logic                  bypass_pop_valid;
  logic [addr_width-1:0] rd_addr;

  // ------------------------------
  // Head selection
  // ------------------------------

  // The bypass is accepted only when the push can leave at once.
  // With pop_ready low the push lands in the RAM and shows up next cycle
  assign bypass_ready     = enable_bypass && empty && pop_ready;
  assign bypass_pop_valid = enable_bypass && bypass_valid_unstable;

  // The RAM is read at the head whenever it holds something
  assign ram_rd_addr_valid = !empty;
  assign ram_rd_addr       = rd_addr;

  // Zero read latency lets the RAM data drive pop directly
  assign pop_valid = empty ? bypass_pop_valid : ram_rd_data_valid;
  assign pop_data  = empty ? bypass_data_unstable : ram_rd_data;

  // Only a handshake on RAM data frees a RAM entry
  assign ram_pop = !empty && ram_rd_data_valid && pop_ready;

  // Read pointer follows the write pointer around the same wrap point
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_addr <= '0;
    end else if (ram_pop) begin
      if (rd_addr == addr_width'(depth - 1)) begin
        rd_addr <= '0;
      end else begin
        rd_addr <= rd_addr + 1'b1;
      end
    end
  end

  // ------------------------------
  // Item count
  // ------------------------------

  // Bypassed entries never occupy the RAM and leave the count alone
  assign items_next = items + count_width'(ram_push) - count_width'(ram_pop);
  assign empty_next = (items_next == '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      items <= '0;
      empty <= 1'b1;
    end else begin
      items <= items_next;
      empty <= empty_next;
    end
  end

endmodule : fifo_pop_ctrl

// File: hw/fifo_ctrl_1r1w_push_credit.sv
// FIFO controller, 1R1W, push credit/valid and pop ready/valid
// Joins the push and pop controllers and exposes the ports of an
// external pseudo-dual-port RAM with a write latency of one cycle
// and a read latency of zero

`timescale 1ns/1ps

module fifo_ctrl_1r1w_push_credit #(
  parameter int depth = 4,
  parameter int bit_width = 8,
  parameter bit enable_bypass = 1'b1,
  parameter int max_credit = depth,
  localparam int addr_width = $clog2(depth),
  localparam int count_width = $clog2(depth + 1),
  localparam int credit_width = credit_pkg::credit_width(max_credit)
) (
  input  logic                    clk,
  input  logic                    rst_n,
  // Push interface
  input  logic                    push_credit_stall,
  output logic                    push_credit,
  input  logic                    push_valid,
  input  logic [bit_width-1:0]    push_data,
  // Pop interface
  input  logic                    pop_ready,
  output logic                    pop_valid,
  output logic [bit_width-1:0]    pop_data,
  // Status
  output logic                    full,
  output logic                    full_next,
  output logic [count_width-1:0]  slots,
  output logic [count_width-1:0]  slots_next,
  output logic                    empty,
  output logic                    empty_next,
  output logic [count_width-1:0]  items,
  output logic [count_width-1:0]  items_next,
  // Credits
  input  logic [credit_width-1:0] credit_initial_push,
  input  logic [credit_width-1:0] credit_withhold_push,
  output logic [credit_width-1:0] credit_count_push,
  // RAM ports
  output logic                    ram_wr_valid,
  output logic [addr_width-1:0]   ram_wr_addr,
  output logic [bit_width-1:0]    ram_wr_data,
  output logic                    ram_rd_addr_valid,
  output logic [addr_width-1:0]   ram_rd_addr,
  input  logic                    ram_rd_data_valid,
  input  logic [bit_width-1:0]    ram_rd_data
);

  // ------------------------------
  // Parameter checks
  // ------------------------------

  if (depth < 2) begin : gen_depth_check
    $error("depth must be at least 2");
  end

  // A smaller ceiling could not hold the credits of a completely empty FIFO
  if (max_credit < depth) begin : gen_credit_check
    $error("max_credit must be at least depth");
  end

  // ------------------------------
  // Controllers
  // ------------------------------

  // Bypass offer and the two occupancy strobes between the halves
  logic                 bypass_ready;
  logic                 bypass_valid_unstable;
  logic [bit_width-1:0] bypass_data_unstable;
  logic                 ram_push;
  logic                 ram_pop;

  fifo_push_ctrl_credit #(
    .depth         (depth),
    .bit_width     (bit_width),
    .enable_bypass (enable_bypass),
    .max_credit    (max_credit)
  ) u_push_ctrl (.*);

  fifo_pop_ctrl #(
    .depth         (depth),
    .bit_width     (bit_width),
    .enable_bypass (enable_bypass)
  ) u_pop_ctrl (.*);

endmodule : fifo_ctrl_1r1w_push_credit

// File: hw/fifo_ram_1r1w.sv
// Flop-based 1R1W RAM
// Pseudo-dual-port register array with a one-cycle write and a
// combinational read. A write is visible to reads from the next cycle

`timescale 1ns/1ps

module fifo_ram_1r1w #(
  parameter int depth = 4,
  parameter int bit_width = 8,
  localparam int addr_width = $clog2(depth)
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wr_valid,
  input  logic [addr_width-1:0] wr_addr,
  input  logic [bit_width-1:0]  wr_data,
  input  logic                  rd_addr_valid,
  input  logic [addr_width-1:0] rd_addr,
  output logic                  rd_data_valid,
  output logic [bit_width-1:0]  rd_data
);

  logic [bit_width-1:0] mem [depth];
  logic [depth-1:0]     written;

  // Storage itself holds no reset value
  always_ff @(posedge clk) begin
    if (wr_valid) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Per-entry flag of whether the entry was ever written since reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      written <= '0;
    end else if (wr_valid) begin
      written[wr_addr] <= 1'b1;
    end
  end

  // Entries never written read as zero, which keeps X out of the pop mux
  assign rd_data = written[rd_addr] ? mem[rd_addr] : '0;

  // Zero read latency: the data is valid in the cycle of its address
  assign rd_data_valid = rd_addr_valid;

endmodule : fifo_ram_1r1w

// File: hw/fifo_credit_top.sv
// Credit FIFO subsystem
// FIFO controller with a credit/valid push side and a ready/valid pop
// side, joined to its flop RAM. All geometry is set here and passed down

`timescale 1ns/1ps

module fifo_credit_top #(
  parameter int depth = fifo_pkg::default_depth,
  parameter int bit_width = fifo_pkg::default_bit_width,
  parameter bit enable_bypass = fifo_pkg::default_enable_bypass,
  parameter int max_credit = credit_pkg::default_max_credit,
  localparam int addr_width = $clog2(depth),
  localparam int count_width = $clog2(depth + 1),
  localparam int credit_width = credit_pkg::credit_width(max_credit)
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    push_credit_stall,
  output logic                    push_credit,
  input  logic                    push_valid,
  input  logic [bit_width-1:0]    push_data,
  input  logic                    pop_ready,
  output logic                    pop_valid,
  output logic [bit_width-1:0]    pop_data,
  output logic                    full,
  output logic                    full_next,
  output logic [count_width-1:0]  slots,
  output logic [count_width-1:0]  slots_next,
  output logic                    empty,
  output logic                    empty_next,
  output logic [count_width-1:0]  items,
  output logic [count_width-1:0]  items_next,
  input  logic [credit_width-1:0] credit_initial_push,
  input  logic [credit_width-1:0] credit_withhold_push,
  output logic [credit_width-1:0] credit_count_push
);

  // ------------------------------
  // RAM port wires
  // ------------------------------

  logic                  ram_wr_valid;
  logic [addr_width-1:0] ram_wr_addr;
  logic [bit_width-1:0]  ram_wr_data;
  logic                  ram_rd_addr_valid;
  logic [addr_width-1:0] ram_rd_addr;
  logic                  ram_rd_data_valid;
  logic [bit_width-1:0]  ram_rd_data;

  fifo_ctrl_1r1w_push_credit #(
    .depth         (depth),
    .bit_width     (bit_width),
    .enable_bypass (enable_bypass),
    .max_credit    (max_credit)
  ) u_ctrl (.*);

  fifo_ram_1r1w #(
    .depth     (depth),
    .bit_width (bit_width)
  ) u_ram (
    .clk           (clk),
    .rst_n         (rst_n),
    .wr_valid      (ram_wr_valid),
    .wr_addr       (ram_wr_addr),
    .wr_data       (ram_wr_data),
    .rd_addr_valid (ram_rd_addr_valid),
    .rd_addr       (ram_rd_addr),
    .rd_data_valid (ram_rd_data_valid),
    .rd_data       (ram_rd_data)
  );

endmodule : fifo_credit_top

// File: sim/fifo_credit_assert.sv
// Credit FIFO checker
// Bound to the FIFO top level. Keeps a reference queue of pushed words and
// its own count of the credits held by the sender, and checks data order,
// bypass, status counts, credit flow and back-pressure

`timescale 1ns/1ps

module fifo_credit_assert #(
  parameter int depth = 4,
  parameter int bit_width = 8,
  parameter bit enable_bypass = 1'b1,
  parameter int max_credit = depth,
  localparam int count_width = $clog2(depth + 1),
  localparam int credit_width = credit_pkg::credit_width(max_credit)
) (
  input logic                    clk,
  input logic                    rst_n,
  input logic                    push_credit_stall,
  input logic                    push_credit,
  input logic                    push_valid,
  input logic [bit_width-1:0]    push_data,
  input logic                    pop_ready,
  input logic                    pop_valid,
  input logic [bit_width-1:0]    pop_data,
  input logic                    full, full_next, empty, empty_next,
  input logic [count_width-1:0]  slots, slots_next, items, items_next,
  input logic [credit_width-1:0] credit_initial_push,
  input logic [credit_width-1:0] credit_withhold_push,
  input logic [credit_width-1:0] credit_count_push
);

  logic [bit_width-1:0]   ref_q[$];
  logic [bit_width-1:0]   ref_head;
  logic                   ref_empty;
  logic [bit_width-1:0]   exp_pop_data;
  logic                   pop_fire;
  logic                   loaded;
  logic [count_width-1:0] items_next_q;
  logic [count_width-1:0] slots_next_q;
  logic                   empty_next_q;
  logic                   full_next_q;
  int                     sender_credits;
  int                     credit_total;
  int unsigned            fail_count = 0;

  // ------------------------------
  // Reference model
  // ------------------------------

  assign pop_fire = pop_valid && pop_ready;
  // An empty queue means the popped word can only be the one pushed now
  assign exp_pop_data = ref_empty ? push_data : ref_head;
  assign credit_total = sender_credits + int'(credit_count_push) + int'(items);

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ref_q.delete();
      ref_head       <= '0;
      ref_empty      <= 1'b1;
      loaded         <= 1'b0;
      sender_credits <= 0;
      items_next_q   <= '0;
      slots_next_q   <= count_width'(depth);
      empty_next_q   <= 1'b1;
      full_next_q    <= 1'b0;
    end else begin
      // A word pushed and popped in the same cycle passes straight through
      if (push_valid) begin
        ref_q.push_back(push_data);
      end
      if (pop_fire && ref_q.size() > 0) begin
        void'(ref_q.pop_front());
      end
      ref_head       <= (ref_q.size() > 0) ? ref_q[0] : '0;
      ref_empty      <= (ref_q.size() == 0);
      // The credit count holds its initial value from the second cycle on
      loaded         <= 1'b1;
      sender_credits <= sender_credits + int'(push_credit) - int'(push_valid);
      items_next_q   <= items_next;
      slots_next_q   <= slots_next;
      empty_next_q   <= empty_next;
      full_next_q    <= full_next;
    end
  end

  // ------------------------------
  // Data and bypass
  // ------------------------------

  a_data_order: assert property (@(posedge clk) disable iff (!rst_n)
      pop_fire |-> (push_valid || !ref_empty) && pop_data == exp_pop_data)
    else begin
      fail_count++;
      $error("Mismatch pop_data: got %h expected %h",
             $sampled(pop_data), $sampled(exp_pop_data));
    end

  a_bypass: assert property (@(posedge clk) disable iff (!rst_n)
      enable_bypass && push_valid && ref_empty && pop_ready |-> pop_valid)
    else begin
      fail_count++;
      $error("A push into an empty FIFO did not reach pop in the same cycle");
    end

  // Head stays put under back-pressure
  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
      pop_valid && !pop_ready |=> pop_valid && $stable(pop_data))
    else begin
      fail_count++;
      $error("pop_valid or pop_data changed while pop_ready was low");
    end

  // ------------------------------
  // Status counts
  // ------------------------------

  a_counts: assert property (@(posedge clk) disable iff (!rst_n)
      items + slots == depth && empty == (items == 0) && full == (slots == 0))
    else begin
      fail_count++;
      $error("Mismatch status: items %h slots %h empty %h full %h",
             $sampled(items), $sampled(slots), $sampled(empty), $sampled(full));
    end

  // Every _next output must show the registered value of the following edge
  a_next: assert property (@(posedge clk) disable iff (!rst_n)
      items == items_next_q && slots == slots_next_q
      && empty == empty_next_q && full == full_next_q)
    else begin
      fail_count++;
      $error("Mismatch items/slots/empty/full: got %h/%h/%h/%h expected %h/%h/%h/%h",
             $sampled(items), $sampled(slots), $sampled(empty), $sampled(full),
             $sampled(items_next_q), $sampled(slots_next_q),
             $sampled(empty_next_q), $sampled(full_next_q));
    end

  // ------------------------------
  // Credits
  // ------------------------------

  a_conserve: assert property (@(posedge clk) disable iff (!rst_n)
      loaded |-> credit_total == int'(credit_initial_push))
    else begin
      fail_count++;
      $error("Mismatch credit total: got %h expected %h",
             $sampled(credit_total), $sampled(credit_initial_push));
    end

  a_push_allowed: assert property (@(posedge clk) disable iff (!rst_n)
      push_valid |-> !full && sender_credits > 0)
    else begin
      fail_count++;
      $error("A push arrived without a credit or while the FIFO was full");
    end

  a_credit_ctrl: assert property (@(posedge clk) disable iff (!rst_n)
      push_credit |-> !push_credit_stall && credit_count_push > credit_withhold_push)
    else begin
      fail_count++;
      $error("A credit was returned while stalled or at the withhold level");
    end

endmodule : fifo_credit_assert

// Attach the checker to every instance of the FIFO top level
bind fifo_credit_top fifo_credit_assert #(
  .depth         (depth),
  .bit_width     (bit_width),
  .enable_bypass (enable_bypass),
  .max_credit    (max_credit)
) u_assert (.*);

// File: sim/tb_fifo_credit.sv
// Testbench of the credit FIFO subsystem
// A credit-holding sender pushes random words and a receiver pops with a
// random ready, in four phases of different load. The bound checker does
// the checking and this module ends the run on its first failure

`timescale 1ns/1ps

module tb_fifo_credit;

  localparam int depth        = fifo_pkg::default_depth;
  localparam int bit_width    = fifo_pkg::default_bit_width;
  localparam int max_credit   = credit_pkg::default_max_credit;
  localparam int count_width  = $clog2(depth + 1);
  localparam int credit_width = credit_pkg::credit_width(max_credit);
  localparam int num_pushes   = 400;
  // The slowest phase needs about three cycles per push, so 15 leaves a wide margin
  localparam int max_cycles   = num_pushes * 15;

  logic                    clk;
  logic                    rst_n;
  logic                    push_credit_stall;
  logic                    push_credit;
  logic                    push_valid;
  logic [bit_width-1:0]    push_data;
  logic                    pop_ready;
  logic                    pop_valid;
  logic [bit_width-1:0]    pop_data;
  logic                    full, full_next, empty, empty_next;
  logic [count_width-1:0]  slots, slots_next, items, items_next;
  logic [credit_width-1:0] credit_initial_push;
  logic [credit_width-1:0] credit_withhold_push;
  logic [credit_width-1:0] credit_count_push;

  // Load per phase in percent: push density, pop_ready and credit stall
  int push_pct[4]  = '{90, 50, 90, 30};
  int ready_pct[4] = '{90, 30, 50, 100};
  int stall_pct[4] = '{0, 20, 50, 10};
  int sender_credits;
  int pushes      = 0;
  int cycle_count = 0;

  fifo_credit_top #(
    .depth         (depth),
    .bit_width     (bit_width),
    .enable_bypass (1'b1),
    .max_credit    (max_credit)
  ) dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ------------------------------
  // Sender credits and run limits
  // ------------------------------

  // Each credit pulse adds one credit and each push spends one
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sender_credits <= 0;
    end else begin
      sender_credits <= sender_credits + int'(push_credit) - int'(push_valid);
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("TB FAILED");
      $fatal(1, "Timeout after %0d cycles with %0d pushes sent", max_cycles, pushes);
    end
  end

  always @(dut.u_assert.fail_count) begin
    if (dut.u_assert.fail_count != 0) begin
      $display("TB FAILED");
      $fatal(1, "The bound checker reported an assertion failure");
    end
  end

  // ------------------------------
  // Stimulus
  // ------------------------------

  // One cycle of random sender and receiver activity at the load of a phase
  task automatic drive_cycle(input int phase);
    credit_withhold_push = (phase >= 2) ? credit_width'(1) : '0;
    push_credit_stall    = ($urandom_range(99) < stall_pct[phase]);
    pop_ready            = ($urandom_range(99) < ready_pct[phase]);
    push_valid = (sender_credits > 0) && ($urandom_range(99) < push_pct[phase]);
    push_data            = bit_width'($urandom);
    if (push_valid) begin
      pushes++;
    end
  endtask

  initial begin
    void'($urandom(32'h9ff7dcc5));
    rst_n                = 1'b0;
    push_credit_stall    = 1'b0;
    push_valid           = 1'b0;
    push_data            = '0;
    pop_ready            = 1'b0;
    credit_initial_push  = credit_width'(depth);
    credit_withhold_push = '0;
    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;
    while (pushes < num_pushes) begin
      @(posedge clk);
      #1;
      drive_cycle(pushes / 100);
    end
    // Drain with pop_ready held high until the FIFO reports empty
    @(posedge clk);
    #1;
    push_valid        = 1'b0;
    pop_ready         = 1'b1;
    push_credit_stall = 1'b0;
    while (!empty) begin
      @(posedge clk);
      #1;
    end
    // Let the last freed credits travel back to the sender
    repeat (depth + 2) @(posedge clk);
    if (dut.u_assert.fail_count != 0) begin
      $display("TB FAILED");
      $fatal(1, "%0d assertion failures", dut.u_assert.fail_count);
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule : tb_fifo_credit

// File: flist.f
hw/fifo_pkg.sv
hw/credit_pkg.sv
hw/fifo_push_ctrl_credit.sv
hw/fifo_pop_ctrl.sv
hw/fifo_ctrl_1r1w_push_credit.sv
hw/fifo_ram_1r1w.sv
hw/fifo_credit_top.sv
sim/fifo_credit_assert.sv
sim/tb_fifo_credit.sv

// File: Bender.yml
package:
  name: fifo_credit

sources:
  # Packages come first since every module refers to them
  - files:
      - hw/fifo_pkg.sv
      - hw/credit_pkg.sv
  # Controller, RAM and subsystem top level
  - files:
      - hw/fifo_push_ctrl_credit.sv
      - hw/fifo_pop_ctrl.sv
      - hw/fifo_ctrl_1r1w_push_credit.sv
      - hw/fifo_ram_1r1w.sv
      - hw/fifo_credit_top.sv
  # Checker and testbench
  - target: simulation
    files:
      - sim/fifo_credit_assert.sv
      - sim/tb_fifo_credit.sv
